// File: hw/scroll_pkg.sv
// Types and constants of the scroll layer; timing assumes one pixel every second clock
package scroll_pkg;

    typedef logic [10:0] cpu_addr_t;   // Bit 10 high selects the code bank
    typedef logic [7:0]  byte_t;
    typedef logic [8:0]  hpos_t;
    typedef logic [7:0]  vpos_t;
    typedef logic [12:0] rom_addr_t;   // Code MSBs, code, row
    typedef logic [31:0] rom_word_t;   // Eight pixels in board bit order
    typedef logic [3:0]  pix_t;
    typedef logic [7:0]  pal_addr_t;   // Palette bits over pixel bits

    localparam int H_TOTAL     = 384;
    localparam int V_TOTAL     = 264;
    localparam int H_VIS_END   = 256;
    localparam int HBLANK_BIT  = $clog2(H_VIS_END);  // hdump bit 8
    localparam int SCROLL_BIT  = 5;                  // Scrolled row starts here
    localparam int V_VIS_START = 16;
    localparam int V_VIS_END   = 240;

    // Attribute byte fields
    localparam int ATTR_CODE_HI = 7;
    localparam int ATTR_CODE_LO = 6;
    localparam int ATTR_VFLIP   = 5;
    localparam int ATTR_HFLIP   = 4;
    localparam int ATTR_PAL_HI  = 3;
    localparam int ATTR_PAL_LO  = 0;

    typedef struct packed {
        hpos_t hdump;
        vpos_t vdump;
        logic  lhbl;      // Low during horizontal blanking
        logic  lvbl;      // Low during vertical blanking
        logic  pxl_cen;
    } video_timing_t;

    typedef struct packed {
        cpu_addr_t addr;
        byte_t     din;
        logic      rnw;
        logic      vram_cs;
        logic      vscr_cs;
    } cpu_bus_t;

    typedef struct packed {
        pal_addr_t addr;
        pix_t      data;
        logic      en;
    } prom_wr_t;

endpackage

// File: hw/video_timing.sv
// Beam counters for 384x264; vdump is the low byte of the line count, so lines 256-263 alias 0-7
`timescale 1ns/100ps

module video_timing (
    input  logic                      clk,
    input  logic                      rst,
    output scroll_pkg::video_timing_t timing
);

    logic              cen;
    scroll_pkg::hpos_t hcnt;
    scroll_pkg::hpos_t hcnt_nxt;
    logic [8:0]        vcnt;      // Full line count, V_TOTAL needs 9 bits
    logic [8:0]        vcnt_nxt;
    logic              lhbl;
    logic              lvbl;

    // Next beam position, advanced only on the pixel enable
    always_comb begin
        hcnt_nxt = hcnt;
        vcnt_nxt = vcnt;
        if (cen) begin
            if (hcnt == scroll_pkg::hpos_t'(scroll_pkg::H_TOTAL - 1)) begin
                hcnt_nxt = '0;
                if (vcnt == 9'(scroll_pkg::V_TOTAL - 1)) begin
                    vcnt_nxt = '0;
                end else begin
                    vcnt_nxt = vcnt + 1'b1;
                end
            end else begin
                hcnt_nxt = hcnt + 1'b1;
            end
        end
    end

    // Blanking flags follow the next count so they line up with hdump and vdump
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cen  <= 1'b0;
            hcnt <= '0;
            vcnt <= '0;
            lhbl <= 1'b0;
            lvbl <= 1'b0;
        end else begin
            cen  <= ~cen;  // Every second clock
            hcnt <= hcnt_nxt;
            vcnt <= vcnt_nxt;
            lhbl <= ~hcnt_nxt[scroll_pkg::HBLANK_BIT];
            lvbl <= (vcnt_nxt >= 9'(scroll_pkg::V_VIS_START)) &&
                    (vcnt_nxt < 9'(scroll_pkg::V_VIS_END));
        end
    end

    assign timing = '{
        hdump:   hcnt,
        vdump:   vcnt[7:0],
        lhbl:    lhbl,
        lvbl:    lvbl,
        pxl_cen: cen
    };

endmodule

// File: hw/tile_vram.sv
// Two 1 KB banks on one clock; CPU reads and video reads both return one clock later
`timescale 1ns/100ps

module tile_vram (
    input  logic                 clk,
    input  scroll_pkg::cpu_bus_t cpu,
    output scroll_pkg::byte_t    vram_dout,
    input  logic [9:0]           rd_addr,
    output scroll_pkg::byte_t    code,
    output scroll_pkg::byte_t    attr
);

    scroll_pkg::byte_t code_mem [1024];
    scroll_pkg::byte_t attr_mem [1024];

    logic [9:0] cpu_idx;
    logic       code_sel;  // High for the code bank
    logic       we;

    assign cpu_idx  = cpu.addr[9:0];
    assign code_sel = cpu.addr[10];
    assign we       = cpu.vram_cs & ~cpu.rnw;

    // CPU port
    always_ff @(posedge clk) begin
        if (we && code_sel) begin
            code_mem[cpu_idx] <= cpu.din;
        end
        if (we && !code_sel) begin
            attr_mem[cpu_idx] <= cpu.din;
        end
        if (cpu.vram_cs && cpu.rnw) begin
            vram_dout <= code_sel ? code_mem[cpu_idx] : attr_mem[cpu_idx];
        end
    end

    // Video port reads both banks at once
    always_ff @(posedge clk) begin
        code <= code_mem[rd_addr];
        attr <= attr_mem[rd_addr];
    end

endmodule

// File: hw/scroll_layer.sv
// Tile fetch for one column per 8 pixels; rom_data must settle within four pixel enables
`timescale 1ns/100ps

module scroll_layer (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      flip,
    input  scroll_pkg::video_timing_t timing,
    input  scroll_pkg::cpu_bus_t      cpu,
    output scroll_pkg::byte_t         vscr_dout,
    output logic [9:0]                rd_addr,
    input  scroll_pkg::byte_t         code,
    input  scroll_pkg::byte_t         attr,
    output scroll_pkg::rom_addr_t     rom_addr,
    input  scroll_pkg::rom_word_t     rom_data,
    output scroll_pkg::pal_addr_t     pal_addr
);

    scroll_pkg::byte_t     vscr;      // CPU scroll value
    scroll_pkg::byte_t     scr_line;  // Scroll value in use for the current line
    scroll_pkg::byte_t     row;       // Effective row, flip applied
    scroll_pkg::byte_t     hdf;
    scroll_pkg::rom_word_t pxl_data;
    scroll_pkg::pix_t      cur_pal;
    scroll_pkg::pix_t      nxt_pal;   // Palette of the tile being fetched
    scroll_pkg::pix_t      nibble;
    logic                  cur_hf;
    logic                  nxt_hf;
    logic                  vflip;
    logic                  hflip;
    logic [2:0]            fine_row;

    // Gathers the four planes of each pixel into one nibble, pixel 7 ends up in bits 31:28
    function automatic scroll_pkg::rom_word_t unscramble(input scroll_pkg::rom_word_t w);
        scroll_pkg::rom_word_t u;
        int p;
        int h;
        int k;
        u = '0;
        for (p = 0; p < 8; p++) begin
            h = (p / 4) * 16;  // Upper half word for pixels 4-7
            k = p % 4;
            u[4*p +: 4] = {w[h+8+k], w[h+12+k], w[h+k], w[h+4+k]};
        end
        return u;
    endfunction

    assign hdf      = timing.hdump[7:0] ^ {8{flip}};  // Counts down when flipped
    assign vflip    = attr[scroll_pkg::ATTR_VFLIP];
    assign hflip    = attr[scroll_pkg::ATTR_HFLIP];
    assign rd_addr  = {row[7:3], hdf[7:3]};           // 32 rows by 32 columns
    assign fine_row = row[2:0] ^ {3{vflip}};
    assign nibble   = cur_hf ? pxl_data[3:0] : pxl_data[31:28];
    assign pal_addr = {cur_pal, nibble};

    // Scroll register and line row
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vscr      <= '0;
            scr_line  <= '0;
            row       <= '0;
            vscr_dout <= '0;
        end else begin
            if (cpu.vscr_cs && !cpu.rnw) begin
                vscr <= cpu.din;
            end
            if (cpu.vscr_cs && cpu.rnw) begin
                vscr_dout <= vscr;
            end
            if (timing.hdump[scroll_pkg::HBLANK_BIT]) begin
                // Plain row in blanking, scroll picked up for the next line
                scr_line <= vscr;
                row      <= {8{flip}} ^ timing.vdump;
            end else if (timing.hdump[scroll_pkg::SCROLL_BIT]) begin
                row <= {8{flip}} ^ (timing.vdump + scr_line);
            end
        end
    end

    // Address and attributes at hdf 0, word in at hdf 4, one nibble per enable after that.
    // Pixel k of a column is clocked into the PROM output at hdf 8c+5+k
    always_ff @(posedge clk) begin
        if (timing.pxl_cen) begin
            if (hdf[2:0] == 3'd0) begin
                rom_addr <= {attr[scroll_pkg::ATTR_CODE_HI:scroll_pkg::ATTR_CODE_LO],
                             code, fine_row};
                nxt_hf   <= hflip;
                nxt_pal  <= attr[scroll_pkg::ATTR_PAL_HI:scroll_pkg::ATTR_PAL_LO];
            end
            if (hdf[2:0] == 3'd4) begin
                pxl_data <= unscramble(rom_data);
                cur_hf   <= nxt_hf;
                cur_pal  <= nxt_pal;
            end else begin
                pxl_data <= cur_hf ? pxl_data >> 4 : pxl_data << 4;  // Low nibble first on hflip
            end
        end
    end

endmodule

// File: hw/palette_prom.sv
// 256x4 colour PROM with no initial contents; it must be loaded before use
`timescale 1ns/100ps

module palette_prom (
    input  logic                  clk,
    input  scroll_pkg::prom_wr_t  wr,
    input  logic                  pxl_cen,
    input  scroll_pkg::pal_addr_t rd_addr,
    output scroll_pkg::pix_t      pxl
);

    scroll_pkg::pix_t mem [256];

    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;  // Programming port
        end
        // Output holds between pixel enables
        if (pxl_cen) begin
            pxl <= mem[rd_addr];
        end
    end

endmodule

// File: hw/scroll_video.sv
// Scroll layer top; CPU, PROM loading and graphics ROM all run on clk, ROM answers in one clock
`timescale 1ns/100ps

module scroll_video (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      flip,
    input  scroll_pkg::cpu_bus_t      cpu,
    output scroll_pkg::byte_t         vram_dout,
    output scroll_pkg::byte_t         vscr_dout,
    input  scroll_pkg::prom_wr_t      prom_wr,
    output scroll_pkg::rom_addr_t     rom_addr,
    input  scroll_pkg::rom_word_t     rom_data,
    output scroll_pkg::video_timing_t timing,
    output scroll_pkg::pix_t          pxl
);

    logic [9:0]            rd_addr;
    scroll_pkg::byte_t     code;
    scroll_pkg::byte_t     attr;
    scroll_pkg::pal_addr_t pal_addr;

    video_timing u_timing (
        .clk    (clk),
        .rst    (rst),
        .timing (timing)
    );

    tile_vram u_vram (
        .clk       (clk),
        .cpu       (cpu),
        .vram_dout (vram_dout),
        .rd_addr   (rd_addr),
        .code      (code),
        .attr      (attr)
    );

    scroll_layer u_layer (
        .clk       (clk),
        .rst       (rst),
        .flip      (flip),
        .timing    (timing),
        .cpu       (cpu),
        .vscr_dout (vscr_dout),
        .rd_addr   (rd_addr),
        .code      (code),
        .attr      (attr),
        .rom_addr  (rom_addr),
        .rom_data  (rom_data),
        .pal_addr  (pal_addr)
    );

    palette_prom u_prom (
        .clk     (clk),
        .wr      (prom_wr),
        .pxl_cen (timing.pxl_cen),
        .rd_addr (pal_addr),
        .pxl     (pxl)
    );

endmodule

// File: dv/scroll_video_props.sv
// Bound into scroll_video; checks are held off in reset and on the first clock after it
`timescale 1ns/100ps

module scroll_video_props (
    input logic                      clk,
    input logic                      rst,
    input scroll_pkg::video_timing_t timing,
    input scroll_pkg::rom_addr_t     rom_addr
);

    int fail_count = 0;  // Read by the testbench at the end

    cen_toggle: assert property (@(posedge clk) disable iff (rst)
        !$past(rst) |-> timing.pxl_cen != $past(timing.pxl_cen))
        else begin
            $error("pxl_cen did not alternate");
            fail_count++;
        end

    hdump_range: assert property (@(posedge clk) disable iff (rst)
        timing.hdump < scroll_pkg::H_TOTAL)
        else begin
            $error("hdump reached %0d", timing.hdump);
            fail_count++;
        end

    // Blanking flag tracks the top bit of the visible count
    lhbl_match: assert property (@(posedge clk) disable iff (rst)
        !$past(rst) |-> timing.lhbl == !timing.hdump[scroll_pkg::HBLANK_BIT])
        else begin
            $error("lhbl disagrees with hdump %0d", timing.hdump);
            fail_count++;
        end

    rom_addr_on_cen: assert property (@(posedge clk) disable iff (rst)
        $changed(rom_addr) |-> $past(timing.pxl_cen))
        else begin
            $error("rom_addr changed without a pixel enable");
            fail_count++;
        end

endmodule

bind scroll_video scroll_video_props u_props (
    .clk      (clk),
    .rst      (rst),
    .timing   (timing),
    .rom_addr (rom_addr)
);

// File: dv/scroll_video_tb.sv
// Runs a step table against scroll_video; the ROM model answers one clock after rom_addr
`timescale 1ns/100ps

module scroll_video_tb;

    typedef enum logic [3:0] {
        VRAM_WR, VRAM_RD, SCR_WR, SCR_RD, PROM_WR, PROM_FILL, SET_FLIP, SAMPLE, RESET, END_TEST
    } op_e;

    typedef struct packed {
        op_e         op;
        logic [10:0] addr;
        logic [7:0]  data;   // Line number for SAMPLE
    } step_t;

    logic                      clk;
    logic                      rst;
    logic                      flip;
    scroll_pkg::cpu_bus_t      cpu;
    scroll_pkg::byte_t         vram_dout;
    scroll_pkg::byte_t         vscr_dout;
    scroll_pkg::prom_wr_t      prom_wr;
    scroll_pkg::rom_addr_t     rom_addr;
    scroll_pkg::rom_word_t     rom_data;
    scroll_pkg::video_timing_t timing;
    scroll_pkg::pix_t          pxl;

    // Mirrors of what the DUT should hold
    scroll_pkg::byte_t code_m [1024];
    scroll_pkg::byte_t attr_m [1024];
    scroll_pkg::pix_t  prom_m [256];
    scroll_pkg::byte_t scr_ref;
    logic              flip_ref;
    step_t             steps [$];
    string             names [6] = '{"vram", "scroll", "attributes", "palette", "flip", "reset"};
    int                seed = 55138;
    int                errors;
    int                cycles;
    int                cycle_limit;

    scroll_video u_dut (.*);

    always #2 clk = ~clk;

    always @(posedge clk) rom_data <= rom_word(rom_addr);  // One clock of ROM latency

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout after %0d clocks, the step table did not finish", cycles);
            $display("Testbench failed");
            $finish;
        end
    end

    // Mixes the whole address into a word
    function automatic scroll_pkg::rom_word_t rom_word(input scroll_pkg::rom_addr_t a);
        return (32'(a) * 32'h9e3779b1) ^ {a, a, a[5:0]};
    endfunction

    // Pixel p takes one bit from each of four 4-bit planes in its half word
    function automatic scroll_pkg::pix_t pixel_bits(input scroll_pkg::rom_word_t w, input int p);
        int base;
        int j;
        base = (p >= 4) ? 16 : 0;
        j = p % 4;
        return {w[base + 8 + j], w[base + 12 + j], w[base + j], w[base + 4 + j]};
    endfunction

    // Predicted pxl while hdump reads h on line v
    function automatic scroll_pkg::pix_t expect_pixel(input int h, input int v);
        int         a;
        int         k;
        logic [7:0] mask;
        logic [7:0] hdf_a;
        logic [7:0] row;
        logic [7:0] at_a;
        logic [9:0] tile_a;
        logic [2:0] fine;
        mask = {8{flip_ref}};
        // Last address enable at least six pixels back
        a = flip_ref ? (((h - 5) & ~7) - 1) : ((h - 6) & ~7);
        k = h - 6 - a;
        hdf_a = 8'(a) ^ mask;
        row = mask ^ 8'(v + scr_ref);
        tile_a = {row[7:3], hdf_a[7:3]};
        at_a = attr_m[tile_a];  // Code, palette and both flips come from this tile
        fine = row[2:0] ^ {3{at_a[scroll_pkg::ATTR_VFLIP]}};
        return prom_m[{at_a[3:0], pixel_bits(rom_word({at_a[7:6], code_m[tile_a], fine}),
                                             at_a[scroll_pkg::ATTR_HFLIP] ? k : 7 - k)}];
    endfunction

    task automatic check_value(input string name, input logic [15:0] exp,
                               input logic [15:0] act);
        assert (act === exp) else begin
            $display("[ERROR] %0t %s expected %0h got %0h", $time, name, exp, act);
            errors++;
        end
    endtask

    // One strobe cycle, results are stable at the following negedge
    task automatic cpu_access(input scroll_pkg::cpu_bus_t req);
        @(posedge clk);
        cpu <= req;
        @(posedge clk);
        cpu <= '0;
        @(negedge clk);
    endtask

    task automatic vram_write(input scroll_pkg::cpu_addr_t a, input scroll_pkg::byte_t d);
        cpu_access('{addr: a, din: d, rnw: 1'b0, vram_cs: 1'b1, vscr_cs: 1'b0});
        if (a[10]) code_m[a[9:0]] = d;
        else attr_m[a[9:0]] = d;
    endtask

    task automatic prom_write(input scroll_pkg::pal_addr_t a, input scroll_pkg::pix_t d);
        @(posedge clk);
        prom_wr <= '{addr: a, data: d, en: 1'b1};
        @(posedge clk);
        prom_wr <= '0;
        prom_m[a] = d;
    endtask

    // Waits for a blanking interval so a new scroll value is picked up, then checks 200 pixels
    task automatic sample_line(input scroll_pkg::vpos_t line);
        int i;
        @(negedge clk);
        while (timing.hdump != 9'd256) @(negedge clk);
        while (!(timing.vdump == line && timing.hdump == 9'd48 && !timing.pxl_cen)) begin
            @(negedge clk);
        end
        for (i = 0; i < 200; i++) begin
            check_value("pxl", expect_pixel(timing.hdump, timing.vdump), pxl);
            @(negedge clk);
            @(negedge clk);
        end
    endtask

    task automatic reset_check();
        @(posedge clk);
        rst <= 1'b1;
        repeat (10) @(posedge clk);
        @(negedge clk);
        check_value("timing.hdump", 0, timing.hdump);
        check_value("timing.vdump", 0, timing.vdump);
        check_value("timing.lhbl", 0, timing.lhbl);
        check_value("timing.lvbl", 0, timing.lvbl);
        @(posedge clk);
        rst <= 1'b0;
        scr_ref = '0;
    endtask

    task automatic build_steps();
        steps.push_back('{VRAM_WR, 11'h405, 8'h5a});
        steps.push_back('{VRAM_WR, 11'h005, 8'hc3});
        steps.push_back('{VRAM_RD, 11'h405, 8'h00});
        steps.push_back('{VRAM_RD, 11'h005, 8'h00});
        steps.push_back('{VRAM_WR, 11'h7ff, 8'h81});
        steps.push_back('{VRAM_RD, 11'h3ff, 8'h00});  // Other bank untouched
        steps.push_back('{VRAM_RD, 11'h7ff, 8'h00});
        steps.push_back('{END_TEST, 11'h000, 8'h00});
        steps.push_back('{SCR_WR, 11'h000, 8'h23});
        steps.push_back('{SCR_RD, 11'h000, 8'h00});
        steps.push_back('{SAMPLE, 11'h000, 8'd40});
        steps.push_back('{END_TEST, 11'h000, 8'h00});
        // Tile row 11 is shown on line 60 with scroll 0x23
        steps.push_back('{VRAM_WR, 11'h166, 8'h15});
        steps.push_back('{VRAM_WR, 11'h167, 8'h26});
        steps.push_back('{VRAM_WR, 11'h168, 8'h77});
        steps.push_back('{VRAM_WR, 11'h169, 8'hc8});
        steps.push_back('{SAMPLE, 11'h000, 8'd60});
        steps.push_back('{END_TEST, 11'h000, 8'h00});
        steps.push_back('{PROM_FILL, 11'h000, 8'h00});
        steps.push_back('{PROM_WR, 11'h05a, 8'h03});
        steps.push_back('{SAMPLE, 11'h000, 8'd80});
        steps.push_back('{END_TEST, 11'h000, 8'h00});
        steps.push_back('{SET_FLIP, 11'h000, 8'h01});
        steps.push_back('{SAMPLE, 11'h000, 8'd100});
        steps.push_back('{SET_FLIP, 11'h000, 8'h00});
        steps.push_back('{END_TEST, 11'h000, 8'h00});
        steps.push_back('{RESET, 11'h000, 8'h00});
        steps.push_back('{SCR_RD, 11'h000, 8'h00});
        steps.push_back('{END_TEST, 11'h000, 8'h00});
    endtask

    initial begin
        step_t s;
        int    i;
        int    id;
        int    mark;
        int    n_pass;
        int    n_fail;
        clk = 1'b0;
        rst = 1'b1;
        flip = 1'b0;
        cpu = '0;
        prom_wr = '0;
        rom_data = '0;
        errors = 0;
        cycles = 0;
        scr_ref = '0;
        flip_ref = 1'b0;
        id = 0;
        mark = 0;
        n_pass = 0;
        n_fail = 0;
        // Three frames of two clocks per pixel, plus 10%
        cycle_limit = 3 * 2 * scroll_pkg::H_TOTAL * scroll_pkg::V_TOTAL * 11 / 10;
        build_steps();
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        for (i = 0; i < 2048; i++) vram_write(11'(i), 8'($random(seed)));
        for (i = 0; i < 256; i++) prom_write(8'(i), 4'($random(seed)));
        foreach (steps[n]) begin
            s = steps[n];
            case (s.op)
                VRAM_WR: vram_write(s.addr, s.data);
                VRAM_RD: begin
                    cpu_access('{addr: s.addr, din: 8'h00, rnw: 1'b1,
                                 vram_cs: 1'b1, vscr_cs: 1'b0});
                    check_value("vram_dout", s.addr[10] ? code_m[s.addr[9:0]] : attr_m[s.addr[9:0]],
                                vram_dout);
                end
                SCR_WR: begin
                    cpu_access('{addr: '0, din: s.data, rnw: 1'b0, vram_cs: 1'b0, vscr_cs: 1'b1});
                    scr_ref = s.data;
                end
                SCR_RD: begin
                    cpu_access('{addr: '0, din: 8'h00, rnw: 1'b1, vram_cs: 1'b0, vscr_cs: 1'b1});
                    check_value("vscr_dout", scr_ref, vscr_dout);
                end
                PROM_WR: prom_write(s.addr[7:0], s.data[3:0]);
                PROM_FILL: for (i = 0; i < 256; i++) prom_write(8'(i), 4'($random(seed)));
                SET_FLIP: begin
                    @(posedge clk);
                    flip <= s.data[0];
                    flip_ref = s.data[0];
                end
                SAMPLE: sample_line(s.data);
                RESET: reset_check();
                default: begin
                    if (errors == mark) begin
                        n_pass++;
                        $display("Test %0d %s: ok", id, names[id]);
                    end else begin
                        n_fail++;
                        $display("Test %0d %s: %0d errors", id, names[id], errors - mark);
                    end
                    id++;
                    mark = errors;
                end
            endcase
        end
        $display("Tests passed %0d, failed %0d, assertion failures %0d", n_pass, n_fail,
                 u_dut.u_props.fail_count);
        if (n_fail == 0 && errors == 0 && u_dut.u_props.fail_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: scroll_video.f
hw/scroll_pkg.sv
hw/video_timing.sv
hw/tile_vram.sv
hw/scroll_layer.sv
hw/palette_prom.sv
hw/scroll_video.sv
dv/scroll_video_props.sv
dv/scroll_video_tb.sv

// File: Bender.yml
package:
  name: scroll_video

sources:
  - files:
      - hw/scroll_pkg.sv
      - hw/video_timing.sv
      - hw/tile_vram.sv
      - hw/scroll_layer.sv
      - hw/palette_prom.sv
      - hw/scroll_video.sv
  - target: test
    files:
      - dv/scroll_video_props.sv
      - dv/scroll_video_tb.sv
